/* source/dsp_ctrl_pkg.sv */
// ------------------------------
// Constants, program word views and pointer modifier
// decode shared by the DSP control unit
// ------------------------------
`default_nettype none

package dsp_ctrl_pkg;

    localparam int word_w      = 16;
    localparam int t_w         = 5;  // T field
    localparam int ja_w        = 12;
    localparam int do_w        = 11;
    localparam int imm_short_w = 9;

    // Opcode pairs, matched on the top four bits
    localparam logic [t_w-2:0] op_goto_ja   = 4'b0000;
    localparam logic [t_w-2:0] op_call_ja   = 4'b1000;
    localparam logic [t_w-2:0] op_short_imm = 4'b0001; // j, k, rb, re

    localparam logic [t_w-1:0] op_goto_b       = 5'b11000; // ret, iret, goto/call pt
    localparam logic [t_w-1:0] op_acc_store_a0 = 5'b01001;
    localparam logic [t_w-1:0] op_acc_store_a1 = 5'b01011;
    localparam logic [t_w-1:0] op_long_imm     = 5'b01010;
    localparam logic [t_w-1:0] op_ram_load     = 5'b01111; // R=Y
    localparam logic [t_w-1:0] op_ram_store    = 5'b01100; // Y=R
    localparam logic [t_w-1:0] op_f1_y         = 5'b00110;
    localparam logic [t_w-1:0] op_f1_at_y      = 5'b00111;
    localparam logic [t_w-1:0] op_f1_x_y       = 5'b10110;
    localparam logic [t_w-1:0] op_do           = 5'b01110;

    localparam logic [2:0] goto_b_iret = 3'b001; // bits 10:8 of goto B

    // Destination class in bits 9:7
    localparam logic [2:0] dest_yaau = 3'b000;
    localparam logic [2:0] dest_xaau = 3'b001;
    localparam logic [2:0] dest_dau  = 3'b010;

    localparam logic [2:0] rsel_dau_acc = 3'b010;

    // Same program word, seen as opcode plus operand or as a jump
    typedef union packed {
        struct packed {
            logic [t_w-1:0]        op;
            logic [word_w-t_w-1:0] operand;
        } fmt;
        struct packed {
            logic [t_w-2:0]  prefix;
            logic [ja_w-1:0] ja;      // top bit is the opcode low bit
        } jump;
    } instr_u;

    // Pointer post-modify, returns {inc_sel, step_sel}
    function automatic logic [2:0] ymod_map(input logic [1:0] ymod);
        logic [2:0] sel;
        case (ymod)
            2'd0:    sel = {2'd1, 1'b0}; // *rN
            2'd1:    sel = {2'd2, 1'b0}; // *rN++
            2'd2:    sel = {2'd0, 1'b0}; // *rN--
            default: sel = {2'd0, 1'b1}; // *rN++j
        endcase
        return sel;
    endfunction

endpackage

`default_nettype wire

/* source/flow_decode.sv */
// ------------------------------
// Branch, call, return and do-loop decode
// Combinational, one program word in
// ------------------------------
`default_nettype none

module flow_decode (
    input  logic [dsp_ctrl_pkg::word_w-1:0] rom_dout,
    input  logic                            con_result,
    output logic                            hit,
    output logic                            two_word,
    output logic                            goto_ja,
    output logic                            call_ja,
    output logic                            goto_b,
    output logic                            halt,
    output logic                            do_start,
    output logic [dsp_ctrl_pkg::do_w-1:0]   do_data
);
    import dsp_ctrl_pkg::*;

    instr_u word;
    logic   is_ja, is_call, is_b, is_do;
    logic   b_taken;
    logic   do_block;

    assign word    = rom_dout;
    assign is_ja   = word.jump.prefix == op_goto_ja;
    assign is_call = word.jump.prefix == op_call_ja;
    assign is_b    = word.fmt.op == op_goto_b;
    assign is_do   = word.fmt.op == op_do;

    // iret is taken whatever the condition
    assign b_taken  = con_result | (word.fmt.operand[10:8] == goto_b_iret);
    assign do_block = word.fmt.operand[10:7] == 4'd0; // zero repeat count

    assign goto_ja  = is_ja & con_result;
    assign call_ja  = is_call & con_result;
    assign goto_b   = is_b & b_taken;
    assign halt     = ((is_ja | is_call) & ~con_result) | (is_b & ~b_taken)
                    | (is_do & do_block);
    assign do_start = is_do;
    assign do_data  = word.fmt.operand;

    assign hit      = is_ja | is_call | is_b | is_do;
    assign two_word = is_ja | is_call | is_b | (is_do & do_block);

    // One branch kind per word, condition included
    always_comb begin
        if (!$isunknown({rom_dout, con_result}))
            assert final ($onehot0({goto_ja, call_ja, goto_b}));
    end

endmodule

`default_nettype wire

/* source/xfer_decode.sv */
// ------------------------------
// Immediate loads, accumulator stores and
// register to RAM transfers
// ------------------------------
`default_nettype none

module xfer_decode (
    input  logic [dsp_ctrl_pkg::word_w-1:0] rom_dout,
    output logic       hit, two_word, halt,
    output logic       short_load, long_load, xaau_imm_load, dau_imm_load,
    output logic       ram_load, xaau_ram_load, dau_ram_load,
    output logic       acc_load, xaau_acc_load, dau_acc_load, acc_sel,
    output logic       ram_we, post_load, step_sel,
    output logic [2:0] r_field, rsel,
    output logic [1:0] a_field, inc_sel
);
    import dsp_ctrl_pkg::*;

    instr_u     word;
    logic [2:0] dest;
    logic [1:0] acc_dest;

    assign word     = rom_dout;
    assign dest     = rom_dout[9:7];
    assign acc_dest = rom_dout[8:7];

    always_comb begin
        {hit, two_word, halt, acc_sel, ram_we, post_load, step_sel} = '0;
        {short_load, long_load, xaau_imm_load, dau_imm_load} = '0;
        {ram_load, xaau_ram_load, dau_ram_load} = '0;
        {acc_load, xaau_acc_load, dau_acc_load} = '0;
        r_field = 3'd0;
        rsel    = 3'd0;
        a_field = 2'd0;
        inc_sel = 2'd0;
        if (word.fmt.op[t_w-1:1] == op_short_imm) begin
            hit        = 1'b1;
            short_load = 1'b1;
            r_field    = rom_dout[11:9] ^ 3'b100;
        end else begin
            case (word.fmt.op)
                op_long_imm: begin
                    hit           = 1'b1;
                    two_word      = 1'b1; // immediate is the next word
                    long_load     = dest == dest_yaau;
                    xaau_imm_load = dest == dest_xaau;
                    dau_imm_load  = dest == dest_dau;
                    r_field       = rom_dout[6:4];
                end
                op_ram_load, op_ram_store: begin
                    hit       = 1'b1;
                    two_word  = 1'b1;
                    halt      = 1'b1;
                    ram_we    = word.fmt.op == op_ram_store;
                    ram_load      = ~ram_we & (dest == dest_yaau);
                    xaau_ram_load = ~ram_we & (dest == dest_xaau);
                    dau_ram_load  = ~ram_we & (dest == dest_dau);
                    rsel      = rom_dout[8:6];
                    r_field   = rom_dout[6:4];
                    post_load = 1'b1;
                    {inc_sel, step_sel} = ymod_map(rom_dout[1:0]);
                end
                op_acc_store_a0, op_acc_store_a1: begin
                    hit      = 1'b1;
                    two_word = 1'b1;
                    halt     = 1'b1;
                    acc_sel  = 1'b1;
                    rsel     = rsel_dau_acc;
                    r_field  = rom_dout[6:4];
                    a_field  = {1'b1, rom_dout[12]}; // a0 or a1
                    acc_load      = acc_dest == dest_yaau[1:0];
                    xaau_acc_load = acc_dest == dest_xaau[1:0];
                    dau_acc_load  = acc_dest == dest_dau[1:0];
                end
                default: ;
            endcase
        end
    end

    // Only one register file takes the value
    always_comb begin
        if (!$isunknown(rom_dout))
            assert final ($onehot0({short_load, long_load, xaau_imm_load, dau_imm_load,
                ram_load, xaau_ram_load, dau_ram_load, acc_load, xaau_acc_load,
                dau_acc_load}));
    end

endmodule

`default_nettype wire

/* source/f1_decode.sv */
// ------------------------------
// F1 data-move forms feeding the arithmetic unit
// ------------------------------
`default_nettype none

module f1_decode (
    input  logic [dsp_ctrl_pkg::word_w-1:0] rom_dout,
    output logic       hit,
    output logic       dau_dec_en,
    output logic       dau_ram_load,
    output logic       dau_acc_ram,
    output logic       st_a0h,
    output logic       st_a1h,
    output logic       post_load,
    output logic       step_sel,
    output logic [2:0] r_field,
    output logic [1:0] a_field,
    output logic [1:0] inc_sel
);
    import dsp_ctrl_pkg::*;

    instr_u word;
    logic   is_x;

    assign word = rom_dout;
    assign is_x = word.fmt.op == op_f1_x_y;
    assign hit  = (word.fmt.op == op_f1_y) | (word.fmt.op == op_f1_at_y) | is_x;

    assign dau_dec_en   = hit;
    assign a_field      = hit ? rom_dout[10:9] : 2'd0;
    assign dau_ram_load = is_x;
    assign r_field      = {2'b00, hit & ~is_x}; // x for x=Y, y otherwise

    // Accumulator high half to RAM
    assign dau_acc_ram = hit & rom_dout[11];
    assign st_a0h      = dau_acc_ram & ~rom_dout[10];
    assign st_a1h      = dau_acc_ram & rom_dout[10];

    assign post_load           = hit;
    assign {inc_sel, step_sel} = hit ? ymod_map(rom_dout[1:0]) : 3'b000;

    // Single accumulator per store
    always_comb begin
        if (!$isunknown(rom_dout))
            assert final (!(st_a0h && st_a1h));
    end

endmodule

`default_nettype wire

/* source/ctrl_regs.sv */
// ------------------------------
// Output registers of the control unit
// Merges decoders, second words and faults
// ------------------------------
`default_nettype none

module ctrl_regs (
    input  logic clk, rst, cen,
    input  logic [dsp_ctrl_pkg::word_w-1:0] rom_dout,
    input  logic flow_hit, flow_two_word, flow_goto_ja, flow_call_ja, flow_goto_b,
    input  logic flow_halt, flow_do_start,
    input  logic [dsp_ctrl_pkg::do_w-1:0] flow_do_data,
    input  logic xfer_hit, xfer_two_word, xfer_halt, xfer_short_load, xfer_long_load,
    input  logic xfer_xaau_imm_load, xfer_dau_imm_load, xfer_ram_load, xfer_xaau_ram_load,
    input  logic xfer_dau_ram_load, xfer_acc_load, xfer_xaau_acc_load, xfer_dau_acc_load,
    input  logic xfer_acc_sel, xfer_ram_we, xfer_post_load, xfer_step_sel,
    input  logic [2:0] xfer_r_field, xfer_rsel,
    input  logic [1:0] xfer_a_field, xfer_inc_sel,
    input  logic f1_hit, f1_dau_dec_en, f1_dau_ram_load, f1_dau_acc_ram,
    input  logic f1_st_a0h, f1_st_a1h, f1_post_load, f1_step_sel,
    input  logic [2:0] f1_r_field,
    input  logic [1:0] f1_a_field, f1_inc_sel,
    output logic goto_ja, call_ja, goto_b, pc_halt, no_int, do_start,
    output logic short_load, long_load, xaau_imm_load, dau_imm_load,
    output logic ram_load, xaau_ram_load, dau_ram_load,
    output logic acc_load, xaau_acc_load, dau_acc_load, acc_sel, ram_we, post_load,
    output logic step_sel, dau_dec_en, dau_acc_ram, st_a0h, st_a1h, fault,
    output logic [dsp_ctrl_pkg::do_w-1:0] do_data,
    output logic [dsp_ctrl_pkg::imm_short_w-1:0] short_imm,
    output logic [dsp_ctrl_pkg::word_w-1:0] long_imm,
    output logic [2:0] r_field, rsel,
    output logic [1:0] a_field, inc_sel
);
    import dsp_ctrl_pkg::*;

    logic second;  // second program word on rom_dout
    logic dec;

    assign dec      = ~second;
    assign no_int   = ~second;
    assign long_imm = rom_dout; // valid in the second word of a long load

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {second, fault, pc_halt, goto_ja, call_ja, goto_b, do_start} <= '0;
            {short_load, long_load, xaau_imm_load, dau_imm_load} <= '0;
            {ram_load, xaau_ram_load, dau_ram_load, ram_we, post_load} <= '0;
            {acc_load, xaau_acc_load, dau_acc_load, acc_sel} <= '0;
            {dau_dec_en, dau_acc_ram, st_a0h, st_a1h} <= '0;
        end else if (cen) begin
            second        <= dec & (flow_two_word | xfer_two_word);
            pc_halt       <= dec & (flow_halt | xfer_halt);
            goto_ja       <= dec & flow_goto_ja;
            call_ja       <= dec & flow_call_ja;
            goto_b        <= dec & flow_goto_b;
            do_start      <= dec & flow_do_start;
            short_load    <= dec & xfer_short_load;
            long_load     <= dec & xfer_long_load;
            xaau_imm_load <= dec & xfer_xaau_imm_load;
            dau_imm_load  <= dec & xfer_dau_imm_load;
            ram_load      <= dec & xfer_ram_load;
            xaau_ram_load <= dec & xfer_xaau_ram_load;
            dau_ram_load  <= dec & (xfer_dau_ram_load | f1_dau_ram_load);
            acc_load      <= dec & xfer_acc_load;
            xaau_acc_load <= dec & xfer_xaau_acc_load;
            dau_acc_load  <= dec & xfer_dau_acc_load;
            acc_sel       <= dec & xfer_acc_sel;
            ram_we        <= dec & xfer_ram_we;
            post_load     <= dec & (xfer_post_load | f1_post_load);
            dau_dec_en    <= dec & f1_dau_dec_en;
            dau_acc_ram   <= dec & f1_dau_acc_ram;
            st_a0h        <= dec & f1_st_a0h;
            st_a1h        <= dec & f1_st_a1h;
            // Sticky until reset
            fault         <= fault | (dec & ~(flow_hit | xfer_hit | f1_hit));
        end
    end

    // Fields follow the decoder that claimed the word
    always_ff @(posedge clk) begin
        if (cen && dec) begin
            do_data   <= flow_do_data;
            short_imm <= rom_dout[imm_short_w-1:0];
            rsel      <= xfer_rsel;
            r_field   <= xfer_hit ? xfer_r_field : f1_r_field;
            a_field   <= xfer_hit ? xfer_a_field : f1_a_field;
            inc_sel   <= xfer_hit ? xfer_inc_sel : f1_inc_sel;
            step_sel  <= xfer_hit ? xfer_step_sel : f1_step_sel;
        end
    end

    // Failed condition holds the PC, taken branch does not
    assert property (@(posedge clk) disable iff (rst)
        $rose(pc_halt) |-> !(goto_ja || call_ja || goto_b));

    assert property (@(posedge clk) disable iff (rst)
        (cen && second) |=> !(pc_halt || goto_ja || call_ja || goto_b || do_start
            || short_load || long_load || xaau_imm_load || dau_imm_load || ram_load
            || xaau_ram_load || dau_ram_load || acc_load || xaau_acc_load
            || dau_acc_load || acc_sel || ram_we || post_load || dau_dec_en
            || dau_acc_ram || st_a0h || st_a1h));

endmodule

`default_nettype wire

/* source/dsp_ctrl.sv */
// ------------------------------
// DSP instruction decode and control, top level
// ------------------------------
`default_nettype none

module dsp_ctrl (
    input  logic clk, rst, cen,
    input  logic [dsp_ctrl_pkg::word_w-1:0] rom_dout,
    input  logic con_result,
    output logic goto_ja, call_ja, goto_b, pc_halt, no_int, do_start,
    output logic short_load, long_load, xaau_imm_load, dau_imm_load,
    output logic ram_load, xaau_ram_load, dau_ram_load,
    output logic acc_load, xaau_acc_load, dau_acc_load, acc_sel, ram_we, post_load,
    output logic step_sel, dau_dec_en, dau_acc_ram, st_a0h, st_a1h, fault,
    output logic [dsp_ctrl_pkg::do_w-1:0] do_data,
    output logic [dsp_ctrl_pkg::imm_short_w-1:0] short_imm,
    output logic [dsp_ctrl_pkg::word_w-1:0] long_imm,
    output logic [2:0] r_field, rsel,
    output logic [1:0] a_field, inc_sel
);
    import dsp_ctrl_pkg::*;

    logic            flow_hit, flow_two_word, flow_goto_ja, flow_call_ja, flow_goto_b;
    logic            flow_halt, flow_do_start;
    logic [do_w-1:0] flow_do_data;

    logic xfer_hit, xfer_two_word, xfer_halt, xfer_short_load, xfer_long_load;
    logic xfer_xaau_imm_load, xfer_dau_imm_load, xfer_ram_load, xfer_xaau_ram_load;
    logic xfer_dau_ram_load, xfer_acc_load, xfer_xaau_acc_load, xfer_dau_acc_load;
    logic xfer_acc_sel, xfer_ram_we, xfer_post_load, xfer_step_sel;
    logic [2:0] xfer_r_field, xfer_rsel;
    logic [1:0] xfer_a_field, xfer_inc_sel;

    logic f1_hit, f1_dau_dec_en, f1_dau_ram_load, f1_dau_acc_ram;
    logic f1_st_a0h, f1_st_a1h, f1_post_load, f1_step_sel;
    logic [2:0] f1_r_field;
    logic [1:0] f1_a_field, f1_inc_sel;

    flow_decode flow_decode_i (
        .rom_dout(rom_dout), .con_result(con_result),
        .hit(flow_hit), .two_word(flow_two_word),
        .goto_ja(flow_goto_ja), .call_ja(flow_call_ja), .goto_b(flow_goto_b),
        .halt(flow_halt), .do_start(flow_do_start), .do_data(flow_do_data)
    );

    xfer_decode xfer_decode_i (
        .rom_dout(rom_dout),
        .hit(xfer_hit), .two_word(xfer_two_word), .halt(xfer_halt),
        .short_load(xfer_short_load), .long_load(xfer_long_load),
        .xaau_imm_load(xfer_xaau_imm_load), .dau_imm_load(xfer_dau_imm_load),
        .ram_load(xfer_ram_load), .xaau_ram_load(xfer_xaau_ram_load),
        .dau_ram_load(xfer_dau_ram_load), .acc_load(xfer_acc_load),
        .xaau_acc_load(xfer_xaau_acc_load), .dau_acc_load(xfer_dau_acc_load),
        .acc_sel(xfer_acc_sel), .ram_we(xfer_ram_we), .post_load(xfer_post_load),
        .step_sel(xfer_step_sel), .r_field(xfer_r_field), .rsel(xfer_rsel),
        .a_field(xfer_a_field), .inc_sel(xfer_inc_sel)
    );

    f1_decode f1_decode_i (
        .rom_dout(rom_dout),
        .hit(f1_hit), .dau_dec_en(f1_dau_dec_en), .dau_ram_load(f1_dau_ram_load),
        .dau_acc_ram(f1_dau_acc_ram), .st_a0h(f1_st_a0h), .st_a1h(f1_st_a1h),
        .post_load(f1_post_load), .step_sel(f1_step_sel), .r_field(f1_r_field),
        .a_field(f1_a_field), .inc_sel(f1_inc_sel)
    );

    // Port names match the top level and the decoder nets
    ctrl_regs ctrl_regs_i (.*);

endmodule

`default_nettype wire

/* tests/tb_dsp_ctrl.sv */
// ------------------------------
// Self-checking testbench for the DSP control unit
// Random program words checked against a model of the last decoded word
// ------------------------------
`default_nettype none

module tb_dsp_ctrl;

    localparam int cycle_limit = 5000;
    localparam int phase_words = 1000;   // Words in each of the two phases

    logic        clk, rst, cen, con_result;
    logic [15:0] rom_dout;
    logic goto_ja, call_ja, goto_b, pc_halt, no_int, do_start;
    logic short_load, long_load, xaau_imm_load, dau_imm_load;
    logic ram_load, xaau_ram_load, dau_ram_load;
    logic acc_load, xaau_acc_load, dau_acc_load, acc_sel, ram_we, post_load;
    logic step_sel, dau_dec_en, dau_acc_ram, st_a0h, st_a1h, fault;
    logic [10:0] do_data;
    logic [8:0]  short_imm;
    logic [15:0] long_imm;
    logic [2:0]  r_field, rsel;
    logic [1:0]  a_field, inc_sel;

    // Reference model state
    logic [15:0] last_word;
    logic        last_con, last_valid, last_dec, m_second, fault_exp;
    logic [4:0]  last_op;
    logic        dec_ok, any_strobe;
    logic [31:0] rng;
    int cycles = 0;
    int n_iret = 0;
    int n_block_do = 0;
    int n_second = 0;
    int n_fault = 0;

    dsp_ctrl dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [4:0] kept_op(input logic [3:0] idx);
        case (idx)
            4'd0:    return 5'b00000;   // goto JA
            4'd1:    return 5'b00001;
            4'd2:    return 5'b10000;   // call JA
            4'd3:    return 5'b10001;
            4'd4:    return 5'b00010;   // short immediate
            4'd5:    return 5'b00011;
            4'd6:    return 5'b11000;   // goto B
            4'd7:    return 5'b01001;   // R=a0
            4'd8:    return 5'b01011;   // R=a1
            4'd9:    return 5'b01010;   // long immediate
            4'd10:   return 5'b01111;   // R=Y
            4'd11:   return 5'b01100;   // Y=R
            4'd12:   return 5'b00110;
            4'd13:   return 5'b00111;
            4'd14:   return 5'b10110;
            default: return 5'b01110;   // do
        endcase
    endfunction

    // The sixteen opcodes with no decoder behind them
    function automatic logic [4:0] bad_op(input logic [3:0] idx);
        case (idx)
            4'd0:    return 5'b00100;
            4'd1:    return 5'b00101;
            4'd2:    return 5'b01000;
            4'd3:    return 5'b01101;
            4'd4:    return 5'b10010;
            4'd5:    return 5'b10011;
            4'd6:    return 5'b10100;
            4'd7:    return 5'b10101;
            4'd8:    return 5'b10111;
            default: return {2'b11, idx[2:0]};   // 11001 up to 11111
        endcase
    endfunction

    function automatic logic is_kept(input logic [4:0] op);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 16; i++)
            if (kept_op(i[3:0]) == op)
                found = 1'b1;
        return found;
    endfunction

    function automatic logic takes_two_words(input logic [15:0] w);
        logic [4:0] op;
        op = w[15:11];
        if (op[4:1] == 4'b0000 || op[4:1] == 4'b1000 || op == 5'b11000)
            return 1'b1;
        if (op == 5'b01010 || op == 5'b01111 || op == 5'b01100)
            return 1'b1;
        if (op == 5'b01001 || op == 5'b01011)
            return 1'b1;
        return op == 5'b01110 && w[10:7] == 4'd0;   // block do only
    endfunction

    // Expected {inc_sel, step_sel} for the pointer modifier
    function automatic logic [2:0] ymod_expect(input logic [1:0] m);
        case (m)
            2'd0:    return 3'b010;
            2'd1:    return 3'b100;
            2'd2:    return 3'b000;
            default: return 3'b001;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            last_word  <= '0;
            last_con   <= 1'b0;
            last_valid <= 1'b0;
            last_dec   <= 1'b0;
            m_second   <= 1'b0;
            fault_exp  <= 1'b0;
        end else if (cen) begin
            last_word  <= rom_dout;
            last_con   <= con_result;
            last_valid <= 1'b1;
            last_dec   <= !m_second;
            m_second   <= !m_second && takes_two_words(rom_dout);
            if (!m_second && !is_kept(rom_dout[15:11]))
                fault_exp <= 1'b1;
        end
    end

    // How often the rarer cases were reached
    always @(posedge clk) begin
        if (!rst && cen && m_second)
            n_second <= n_second + 1;
        if (!rst && cen && !m_second) begin
            if (rom_dout[15:11] == 5'b11000 && rom_dout[10:8] == 3'b001)
                n_iret <= n_iret + 1;
            if (rom_dout[15:11] == 5'b01110 && rom_dout[10:7] == 4'd0)
                n_block_do <= n_block_do + 1;
            if (!is_kept(rom_dout[15:11]))
                n_fault <= n_fault + 1;
        end
    end

    assign last_op    = last_word[15:11];
    assign dec_ok     = last_valid && last_dec;
    assign any_strobe = pc_halt | goto_ja | call_ja | goto_b | do_start | short_load
                      | long_load | xaau_imm_load | dau_imm_load | ram_load | xaau_ram_load
                      | dau_ram_load | acc_load | xaau_acc_load | dau_acc_load | acc_sel
                      | ram_we | post_load | dau_dec_en | dau_acc_ram | st_a0h | st_a1h;

    task automatic stop_on_error(input string msg);
        $display("ERR at %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && last_op[4:1] == 4'b0000 |-> goto_ja == last_con
            && pc_halt == !last_con && !call_ja && !goto_b)
        else stop_on_error("goto JA strobe or pc_halt does not follow the condition");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && last_op[4:1] == 4'b1000 |-> call_ja == last_con
            && pc_halt == !last_con && !goto_ja && !goto_b)
        else stop_on_error("call JA strobe or pc_halt does not follow the condition");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && last_op == 5'b11000 |->
            goto_b == (last_con || last_word[10:8] == 3'b001)
            && pc_halt == !(last_con || last_word[10:8] == 3'b001))
        else stop_on_error("goto B not taken as expected, iret included");

    assert property (@(posedge clk) disable iff (rst) no_int == !m_second)
        else stop_on_error("no_int wrong around a second program word");

    assert property (@(posedge clk) disable iff (rst)
        last_valid && !last_dec |-> !any_strobe)
        else stop_on_error("strobe high after a second program word");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && last_op == 5'b01010 |-> long_load == (last_word[9:7] == 3'd0)
            && xaau_imm_load == (last_word[9:7] == 3'd1)
            && dau_imm_load == (last_word[9:7] == 3'd2) && !short_load && !ram_load
            && !xaau_ram_load && !dau_ram_load && !acc_load && !xaau_acc_load
            && !dau_acc_load)
        else stop_on_error("long immediate load strobes do not match the class");

    assert property (@(posedge clk) disable iff (rst)
        m_second && last_dec && last_op == 5'b01010 |-> long_imm == rom_dout)
        else stop_on_error("long_imm differs from the second program word");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && last_op[4:1] == 4'b0001 |-> short_load && short_imm == last_word[8:0]
            && r_field == {~last_word[11], last_word[10:9]})
        else stop_on_error("short immediate value or r_field wrong");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && (last_op == 5'b01111 || last_op == 5'b01100) |-> post_load && pc_halt
            && {inc_sel, step_sel} == ymod_expect(last_word[1:0])
            && ram_we == (last_op == 5'b01100))
        else stop_on_error("RAM transfer post-modify or ram_we wrong");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && (last_op == 5'b01001 || last_op == 5'b01011) |-> acc_sel && pc_halt
            && rsel == 3'b010 && a_field[0] == (last_op == 5'b01011)
            && acc_load == (last_word[8:7] == 2'd0)
            && xaau_acc_load == (last_word[8:7] == 2'd1)
            && dau_acc_load == (last_word[8:7] == 2'd2))
        else stop_on_error("accumulator store select or destination wrong");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && last_op != 5'b01100 |-> !ram_we)
        else stop_on_error("ram_we high for a word other than Y=R");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && (last_op == 5'b00110 || last_op == 5'b00111 || last_op == 5'b10110)
            |-> dau_dec_en && a_field == last_word[10:9] && post_load
            && {inc_sel, step_sel} == ymod_expect(last_word[1:0])
            && dau_acc_ram == last_word[11]
            && st_a0h == (last_word[11] && !last_word[10])
            && st_a1h == (last_word[11] && last_word[10]))
        else stop_on_error("F1 form decoded wrongly");

    assert property (@(posedge clk) disable iff (rst)
        dec_ok && last_op == 5'b01110 |-> do_start && do_data == last_word[10:0]
            && pc_halt == (last_word[10:7] == 4'd0))
        else stop_on_error("do start, operand or block halt wrong");

    assert property (@(posedge clk) disable iff (rst) fault == fault_exp)
        else stop_on_error("fault flag does not match the opcodes seen");

    assert property (@(posedge clk) $fell(rst) |-> !any_strobe && no_int && !fault)
        else stop_on_error("outputs not in reset state after reset");

    task automatic drive_words(input int count, input logic allow_bad);
        int         sent;
        logic       en;
        logic [4:0] op;
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            rng = xorshift(rng);
            en = rng[2:0] != 3'd0;   // cen low about one cycle in eight
            if (allow_bad && rng[7:4] == 4'd0)
                op = bad_op(rng[11:8]);
            else
                op = kept_op(rng[19:16]);
            con_result <= rng[23];
            rng = xorshift(rng);
            rom_dout <= {op, rng[10:0]};
            cen      <= en;
            if (en)
                sent++;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        rst        = 1'b1;
        cen        = 1'b0;
        con_result = 1'b0;
        rom_dout   = '0;
        rng        = 32'hc98a_5daf;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        drive_words(phase_words, 1'b0);   // fault must stay low here
        drive_words(phase_words, 1'b1);
        @(posedge clk);
        rst <= 1'b1;
        cen <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        if (n_iret > 0 && n_block_do > 0 && n_second > 0 && n_fault > 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Stimulus missed a case: iret %0d, block do %0d, second %0d, fault %0d",
                n_iret, n_block_do, n_second, n_fault);
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* project.f */
source/dsp_ctrl_pkg.sv
source/flow_decode.sv
source/xfer_decode.sv
source/f1_decode.sv
source/ctrl_regs.sv
source/dsp_ctrl.sv
tests/tb_dsp_ctrl.sv

/* Bender.yml */
package:
  name: dsp_ctrl

sources:
  - source/dsp_ctrl_pkg.sv
  - source/flow_decode.sv
  - source/xfer_decode.sv
  - source/f1_decode.sv
  - source/ctrl_regs.sv
  - source/dsp_ctrl.sv
  - target: test
    files:
      - tests/tb_dsp_ctrl.sv
